// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0 -Wno-fatal
TOP       = tb_race_display
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@! grep -q "Test FAILED" $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/map_read_if.sv
`timescale 1ns/1ps

interface map_read_if;
    import race_pkg::*;

    logic [MAP_ADDR_W-1:0] view_addr;
    logic [MAP_ADDR_W-1:0] mini_addr;
    map_index_t            view_index;  // one cycle after view_addr
    map_index_t            mini_index;

    modport scanner (output view_addr, output mini_addr);
    modport ram     (input view_addr, input mini_addr, output view_index, output mini_index);
    modport mixer   (input view_index, input mini_index);

endinterface

// File: design/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
    input  logic       clk_25MHz,
    input  logic       rst,
    scan_if.mixer      scan,
    map_read_if.mixer  map_rd,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue,
    output logic       hsync,
    output logic       vsync
);
    import race_pkg::*;

    pixel_region_t region_q;
    logic          view_q;
    logic          hsync_q, vsync_q;
    color_t        color;

    // ------------------------------------------------------------
    // line up with the map read data
    // ------------------------------------------------------------
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            region_q <= BLANK;
            view_q   <= 1'b0;
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
        end else begin
            region_q <= scan.region;
            view_q   <= scan.view;
            hsync_q  <= scan.hsync;
            vsync_q  <= scan.vsync;
        end
    end

    always_comb begin
        case (region_q)
            LOBBY:            color = COLOR_LOBBY;
            SEPARATOR:        color = COLOR_SEPARATOR;
            HUD:              color = COLOR_HUD;
            OFF_TRACK:        color = COLOR_OFF_TRACK;
            P1_DOT:           color = COLOR_P1;
            P2_DOT:           color = COLOR_P2;
            P1_MARK, P2_MARK: color = view_q ? COLOR_P2 : COLOR_P1;  // own car of that half
            MINI_MAP:         color = PALETTE[map_rd.mini_index];
            TRACK:            color = PALETTE[map_rd.view_index];
            default:          color = '0;  // blanking
        endcase
    end

    // output registers
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            {vga_red, vga_green, vga_blue} <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            {vga_red, vga_green, vga_blue} <= color;
            hsync <= hsync_q;
            vsync <= vsync_q;
        end
    end

endmodule

// File: design/race_display_top.sv
`timescale 1ns/1ps

module race_display_top #(
    parameter int COUNT_STEP_CYCLES = 25_000_000  // one second per step
) (
    input  logic                             clk_25MHz,
    input  logic                             rst,
    input  logic                             start_btn,
    input  logic                             pause_btn,
    input  logic                             race_done,
    input  logic [race_pkg::COORD_W-1:0]     p1_x,
    input  logic [race_pkg::COORD_W-1:0]     p1_y,
    input  logic [race_pkg::COORD_W-1:0]     p2_x,
    input  logic [race_pkg::COORD_W-1:0]     p2_y,
    input  logic                             map_we,
    input  logic [race_pkg::MAP_ADDR_W-1:0]  map_addr,
    input  race_pkg::map_index_t             map_wdata,
    output logic [3:0]                       vga_red,
    output logic [3:0]                       vga_green,
    output logic [3:0]                       vga_blue,
    output logic                             hsync,
    output logic                             vsync,
    output logic [2:0]                       led
);
    import race_pkg::*;

    race_state_t state;

    scan_if     scan_bus ();
    map_read_if map_bus ();

    race_fsm #(.COUNT_STEP_CYCLES(COUNT_STEP_CYCLES)) u_race_fsm (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .start_btn (start_btn),
        .pause_btn (pause_btn),
        .race_done (race_done),
        .state     (state),
        .led       (led)
    );

    view_scanner u_view_scanner (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .state     (state),
        .p1_x      (p1_x),
        .p1_y      (p1_y),
        .p2_x      (p2_x),
        .p2_y      (p2_y),
        .scan      (scan_bus),
        .map_rd    (map_bus)
    );

    track_map_ram u_track_map_ram (
        .clk_25MHz (clk_25MHz),
        .map_we    (map_we),
        .map_addr  (map_addr),
        .map_wdata (map_wdata),
        .map_rd    (map_bus)
    );

    pixel_mixer u_pixel_mixer (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .scan      (scan_bus),
        .map_rd    (map_bus),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .hsync     (hsync),
        .vsync     (vsync)
    );

endmodule

// File: design/race_fsm.sv
`timescale 1ns/1ps

module race_fsm #(
    parameter int COUNT_STEP_CYCLES = 25_000_000
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 start_btn,
    input  logic                 pause_btn,
    input  logic                 race_done,
    output race_pkg::race_state_t state,
    output logic [2:0]           led
);
    import race_pkg::*;

    typedef logic [$clog2(COUNT_STEP_CYCLES)-1:0] cycle_t;
    typedef logic [$clog2(COUNT_STEPS)-1:0]       step_t;

    race_state_t resume_state;  // where a second pause goes back to
    cycle_t      cycle_cnt;
    step_t       step_cnt;
    logic        cycle_done;
    logic        count_done;

    assign cycle_done = (cycle_cnt == cycle_t'(COUNT_STEP_CYCLES - 1));
    assign count_done = cycle_done && (step_cnt == step_t'(COUNT_STEPS - 1));

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            state        <= IDLE;
            resume_state <= IDLE;
            cycle_cnt    <= '0;
            step_cnt     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_btn) begin
                        state     <= COUNTDOWN;
                        cycle_cnt <= '0;
                        step_cnt  <= '0;
                    end
                end
                COUNTDOWN: begin
                    // the cycle that sees pause still counts
                    if (cycle_done) begin
                        cycle_cnt <= '0;
                        step_cnt  <= count_done ? '0 : step_cnt + 1'b1;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                    if (pause_btn) begin
                        state        <= PAUSE;
                        resume_state <= count_done ? RACING : COUNTDOWN;
                    end else if (count_done) begin
                        state <= RACING;
                    end
                end
                RACING: begin
                    if (race_done) begin
                        state <= FINISH;
                    end else if (pause_btn) begin
                        state        <= PAUSE;
                        resume_state <= RACING;
                    end
                end
                PAUSE: if (pause_btn) state <= resume_state;  // counters held meanwhile
                FINISH: if (start_btn) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign led = state;

endmodule

// File: design/race_pkg.sv
package race_pkg;

    // ------------------------------------------------------------
    // 640x480 scan timing at 25 MHz
    // ------------------------------------------------------------
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;  // 800
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;  // 525

    // ------------------------------------------------------------
    // track map and view geometry
    // ------------------------------------------------------------
    localparam int MAP_WIDTH     = 320;
    localparam int MAP_HEIGHT    = 240;
    localparam int MAP_ADDR_W    = 17;
    localparam int COORD_W       = 10;
    localparam int VIEW_WIDTH    = 320;  // one player half
    localparam int VIEW_SHIFT    = 3;    // 8x8 pixels per map cell
    localparam int VIEW_OFFSET_X = 20;
    localparam int VIEW_OFFSET_Y = 22;
    localparam int HUD_TOP       = 360;
    localparam int MINI_LEFT     = 240;
    localparam int MINI_RIGHT    = 400;
    localparam int DOT_RADIUS    = 4;
    localparam int MARK_LEFT     = 123;  // own car box, view relative
    localparam int MARK_RIGHT    = 197;
    localparam int MARK_TOP      = 143;
    localparam int MARK_BOTTOM   = 217;

    typedef logic [11:0] color_t;     // r g b, four bits each
    typedef logic [3:0]  map_index_t;

    localparam color_t PALETTE [16] = '{
        12'h3A2, 12'h777, 12'hFFF, 12'hD22, 12'hEE3, 12'h22C, 12'h8C8, 12'h555,
        12'hA63, 12'h0CC, 12'hC0C, 12'hFA0, 12'h222, 12'h9DF, 12'h6B4, 12'hCCC
    };

    localparam color_t COLOR_LOBBY     = 12'hBEB;
    localparam color_t COLOR_SEPARATOR = 12'hFFF;
    localparam color_t COLOR_HUD       = 12'h444;
    localparam color_t COLOR_OFF_TRACK = 12'h6B4;
    localparam color_t COLOR_P1        = 12'hF00;
    localparam color_t COLOR_P2        = 12'h00F;

    // same codes as the board leds
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        COUNTDOWN = 3'd3,
        RACING    = 3'd4,
        PAUSE     = 3'd5,
        FINISH    = 3'd6
    } race_state_t;

    localparam int COUNT_STEPS = 3;

    typedef enum logic [3:0] {
        BLANK, LOBBY, SEPARATOR, HUD, MINI_MAP, P1_DOT, P2_DOT,
        P1_MARK, P2_MARK, OFF_TRACK, TRACK
    } pixel_region_t;

endpackage

// File: design/scan_if.sv
`timescale 1ns/1ps

interface scan_if;
    import race_pkg::*;

    logic          hsync;   // active low
    logic          vsync;   // active low
    pixel_region_t region;
    logic          view;    // 0 player 1 half, 1 player 2 half

    // scanner classifies each pixel
    modport scanner (
        output hsync,
        output vsync,
        output region,
        output view
    );

    modport mixer (
        input hsync,
        input vsync,
        input region,
        input view
    );

endinterface

// File: design/track_map_ram.sv
`timescale 1ns/1ps

module track_map_ram (
    input  logic                             clk_25MHz,
    input  logic                             map_we,
    input  logic [race_pkg::MAP_ADDR_W-1:0]  map_addr,
    input  race_pkg::map_index_t             map_wdata,
    map_read_if.ram                          map_rd
);
    import race_pkg::*;

    // one color index per map cell, row major
    map_index_t mem [0:MAP_WIDTH*MAP_HEIGHT-1];

    always_ff @(posedge clk_25MHz) begin
        if (map_we)
            mem[map_addr] <= map_wdata;
    end

    // ------------------------------------------------------------
    // two read ports, main views and minimap
    // ------------------------------------------------------------
    always_ff @(posedge clk_25MHz) begin
        map_rd.view_index <= mem[map_rd.view_addr];
        map_rd.mini_index <= mem[map_rd.mini_addr];  // old data on a same cycle write
    end

endmodule

// File: design/view_scanner.sv
`timescale 1ns/1ps

module view_scanner (
    input  logic                          clk_25MHz,
    input  logic                          rst,
    input  race_pkg::race_state_t         state,
    input  logic [race_pkg::COORD_W-1:0]  p1_x,
    input  logic [race_pkg::COORD_W-1:0]  p1_y,
    input  logic [race_pkg::COORD_W-1:0]  p2_x,
    input  logic [race_pkg::COORD_W-1:0]  p2_y,
    scan_if.scanner                       scan,
    map_read_if.scanner                   map_rd
);
    import race_pkg::*;

    logic [COORD_W-1:0]    h_cnt, v_cnt;
    logic                  right_half;
    logic [COORD_W-1:0]    rel_x;                 // x inside the player half
    logic [COORD_W-1:0]    my_x, my_y;
    logic [COORD_W-1:0]    cell_x, cell_y;        // magnified view cell
    logic [COORD_W-1:0]    mini_x, mini_y;        // minimap cell
    logic                  off_track, mini_off;
    logic                  in_mini_cols, in_mark;
    logic                  hsync_d, vsync_d;
    pixel_region_t         region_d;
    logic [MAP_ADDR_W-1:0] view_addr_d, mini_addr_d;

    // both axes within DOT_RADIUS of a player
    function automatic logic near(input logic [COORD_W-1:0] a, input logic [COORD_W-1:0] b);
        logic [COORD_W-1:0] diff;
        diff = (a >= b) ? a - b : b - a;
        return diff <= COORD_W'(DOT_RADIUS);
    endfunction

    // ------------------------------------------------------------
    // scan counters
    // ------------------------------------------------------------
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == COORD_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == COORD_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign hsync_d = !(h_cnt >= COORD_W'(H_VISIBLE + H_FRONT) &&
                       h_cnt <  COORD_W'(H_VISIBLE + H_FRONT + H_SYNC));
    assign vsync_d = !(v_cnt >= COORD_W'(V_VISIBLE + V_FRONT) &&
                       v_cnt <  COORD_W'(V_VISIBLE + V_FRONT + V_SYNC));

    // ------------------------------------------------------------
    // per half view, left is player 1
    // ------------------------------------------------------------
    assign right_half = (h_cnt >= COORD_W'(VIEW_WIDTH));
    assign rel_x      = right_half ? h_cnt - COORD_W'(VIEW_WIDTH) : h_cnt;
    assign my_x       = right_half ? p2_x : p1_x;
    assign my_y       = right_half ? p2_y : p1_y;

    assign cell_x    = (rel_x >> VIEW_SHIFT) + my_x - COORD_W'(VIEW_OFFSET_X);
    assign cell_y    = (v_cnt >> VIEW_SHIFT) + my_y - COORD_W'(VIEW_OFFSET_Y);
    assign off_track = (cell_x >= COORD_W'(MAP_WIDTH)) || (cell_y >= COORD_W'(MAP_HEIGHT));

    assign view_addr_d = off_track ? '0 :
                         MAP_ADDR_W'(cell_y) * MAP_ADDR_W'(MAP_WIDTH) + MAP_ADDR_W'(cell_x);

    // minimap at half scale, two map cells per pixel
    assign mini_x   = (h_cnt - COORD_W'(MINI_LEFT)) << 1;
    assign mini_y   = (v_cnt - COORD_W'(HUD_TOP)) << 1;
    assign mini_off = (mini_x >= COORD_W'(MAP_WIDTH)) || (mini_y >= COORD_W'(MAP_HEIGHT));

    assign mini_addr_d = mini_off ? '0 :
                         MAP_ADDR_W'(mini_y) * MAP_ADDR_W'(MAP_WIDTH) + MAP_ADDR_W'(mini_x);

    assign in_mini_cols = (h_cnt >= COORD_W'(MINI_LEFT)) && (h_cnt < COORD_W'(MINI_RIGHT));
    assign in_mark      = (rel_x >= COORD_W'(MARK_LEFT)) && (rel_x <= COORD_W'(MARK_RIGHT)) &&
                          (v_cnt >= COORD_W'(MARK_TOP))  && (v_cnt <= COORD_W'(MARK_BOTTOM));

    // region priority, first match wins
    always_comb begin
        if (h_cnt >= COORD_W'(H_VISIBLE) || v_cnt >= COORD_W'(V_VISIBLE))
            region_d = BLANK;
        else if (state == IDLE)
            region_d = LOBBY;
        else if (v_cnt == COORD_W'(HUD_TOP - 1) || v_cnt == COORD_W'(HUD_TOP))
            region_d = SEPARATOR;
        else if (v_cnt > COORD_W'(HUD_TOP)) begin
            if (in_mini_cols && near(mini_x, p1_x) && near(mini_y, p1_y))
                region_d = P1_DOT;
            else if (in_mini_cols && near(mini_x, p2_x) && near(mini_y, p2_y))
                region_d = P2_DOT;
            else if (in_mini_cols)
                region_d = MINI_MAP;
            else
                region_d = HUD;
        end
        else if (h_cnt == COORD_W'(VIEW_WIDTH - 1) || h_cnt == COORD_W'(VIEW_WIDTH))
            region_d = SEPARATOR;
        else if (in_mark)
            region_d = right_half ? P2_MARK : P1_MARK;
        else if (off_track)
            region_d = OFF_TRACK;
        else
            region_d = TRACK;
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            scan.hsync  <= 1'b1;
            scan.vsync  <= 1'b1;
            scan.region <= BLANK;
            scan.view   <= 1'b0;
        end else begin
            scan.hsync  <= hsync_d;
            scan.vsync  <= vsync_d;
            scan.region <= region_d;
            scan.view   <= right_half;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        map_rd.view_addr <= view_addr_d;
        map_rd.mini_addr <= mini_addr_d;
    end

endmodule

// File: sources.f
design/race_pkg.sv
design/scan_if.sv
design/map_read_if.sv
design/race_fsm.sv
design/view_scanner.sv
design/track_map_ram.sv
design/pixel_mixer.sv
design/race_display_top.sv
testbench/race_display_chk.sv
testbench/tb_race_display.sv

// File: testbench/race_display_chk.sv
`timescale 1ns/1ps

module race_display_chk (
    input logic                  clk_25MHz,
    input logic                  rst,
    input logic                  hsync,
    input logic                  vsync,
    input logic [3:0]            vga_red,
    input logic [3:0]            vga_green,
    input logic [3:0]            vga_blue,
    input race_pkg::race_state_t state
);
    import race_pkg::*;

    int hs_low;  // cycles into the current sync pulse
    int vs_low;
    int assert_fails = 0;

    always_ff @(posedge clk_25MHz) begin
        hs_low <= (rst || hsync) ? 0 : hs_low + 1;
        vs_low <= (rst || vsync) ? 0 : vs_low + 1;
    end

    // ------------------------------------------------------------
    // sync widths, blanking and game flow
    // ------------------------------------------------------------
    hsync_width: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(hsync) |-> hs_low == H_SYNC)
        else begin
            $error("hsync pulse was %0d cycles", $sampled(hs_low));
            assert_fails++;
        end

    vsync_width: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(vsync) |-> vs_low == V_SYNC * H_TOTAL)
        else begin
            $error("vsync pulse was %0d cycles", $sampled(vs_low));
            assert_fails++;
        end

    no_skip_countdown: assert property (@(posedge clk_25MHz) disable iff (rst)
        state == IDLE |=> state != RACING)
        else begin
            $error("state went from IDLE straight to RACING");
            assert_fails++;
        end

    dark_in_sync: assert property (@(posedge clk_25MHz) disable iff (rst)
        (!hsync || !vsync) |-> {vga_red, vga_green, vga_blue} == 12'h000)
        else begin
            $error("rgb not zero during a sync pulse");
            assert_fails++;
        end

endmodule

bind race_display_top race_display_chk u_race_display_chk (
    .clk_25MHz (clk_25MHz),
    .rst       (rst),
    .hsync     (hsync),
    .vsync     (vsync),
    .vga_red   (vga_red),
    .vga_green (vga_green),
    .vga_blue  (vga_blue),
    .state     (state)
);

// File: testbench/tb_race_display.sv
`timescale 1ns/1ps

module tb_race_display;
    import race_pkg::*;

    localparam int STEP_CYCLES  = 100;
    localparam int COUNT_CYCLES = COUNT_STEPS * STEP_CYCLES;
    localparam int MAP_CELLS    = MAP_WIDTH * MAP_HEIGHT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // covers reset, map load, state tests and four captures that may each wait a frame
    localparam int MAX_CYCLES   = 10 + MAP_CELLS + 8 * FRAME_CYCLES + 5000;
    localparam int SEL_START    = 0;
    localparam int SEL_PAUSE    = 1;
    localparam int SEL_DONE     = 2;

    logic                  clk_25MHz;
    logic                  rst;
    logic                  start_btn, pause_btn, race_done;
    logic [COORD_W-1:0]    p1_x, p1_y, p2_x, p2_y;
    logic                  map_we;
    logic [MAP_ADDR_W-1:0] map_addr;
    map_index_t            map_wdata;
    logic [3:0]            vga_red, vga_green, vga_blue;
    logic                  hsync, vsync;
    logic [2:0]            led;

    map_index_t  map_copy [MAP_CELLS];  // what the DUT map should hold
    race_state_t exp_state;
    int          seed = 83;
    int          cycle_count = 0;
    int          test_errors, total_errors, tests_run, tests_failed;

    race_display_top #(.COUNT_STEP_CYCLES(STEP_CYCLES)) u_race_display_top (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .start_btn (start_btn),
        .pause_btn (pause_btn),
        .race_done (race_done),
        .p1_x      (p1_x),
        .p1_y      (p1_y),
        .p2_x      (p2_x),
        .p2_y      (p2_y),
        .map_we    (map_we),
        .map_addr  (map_addr),
        .map_wdata (map_wdata),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .hsync     (hsync),
        .vsync     (vsync),
        .led       (led)
    );

    initial clk_25MHz = 1'b0;
    always #20 clk_25MHz = ~clk_25MHz;

    always @(posedge clk_25MHz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, a test hung", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("[pass] %s", name);
        end else begin
            tests_failed++;
            $display("[fail] %s, %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // one cycle pulse where at returns the edge count that samples it
    task automatic strobe(input int which, output int at);
        @(posedge clk_25MHz);
        #2;
        case (which)
            SEL_START: start_btn = 1'b1;
            SEL_PAUSE: pause_btn = 1'b1;
            default:   race_done = 1'b1;
        endcase
        @(posedge clk_25MHz);
        #2;
        at = cycle_count;
        start_btn = 1'b0;
        pause_btn = 1'b0;
        race_done = 1'b0;
    endtask

    task automatic expect_led(input string name, input race_state_t target);
        @(negedge clk_25MHz);
        compare(name, 32'(target), 32'(led));
    endtask

    task automatic wait_for_led(input string name, input race_state_t target, output int at);
        int n;
        n  = 0;
        at = -1;
        while (at < 0 && n < 2 * COUNT_CYCLES + 1000) begin
            @(negedge clk_25MHz);
            if (led == target)
                at = cycle_count;
            n++;
        end
        if (at < 0) begin
            $display("%s: led never showed %s", name, target.name());
            test_errors++;
        end
    endtask

    task automatic write_cell(input int addr, input map_index_t data);
        @(posedge clk_25MHz);
        #2;
        map_we    = 1'b1;  // left high for back to back writes
        map_addr  = MAP_ADDR_W'(addr);
        map_wdata = data;
        map_copy[addr] = data;
    endtask

    task automatic load_map();
        for (int i = 0; i < MAP_CELLS; i++)
            write_cell(i, map_index_t'($random(seed)));
        @(posedge clk_25MHz);
        #2;
        map_we = 1'b0;
    endtask

    task automatic set_players(input int x1, input int y1, input int x2, input int y2);
        @(posedge clk_25MHz);
        #2;
        p1_x = COORD_W'(x1);
        p1_y = COORD_W'(y1);
        p2_x = COORD_W'(x2);
        p2_y = COORD_W'(y2);
    endtask

    function automatic bit within_radius(input int a, input int b);
        return (a - b <= DOT_RADIUS) && (b - a <= DOT_RADIUS);
    endfunction

    // ------------------------------------------------------------
    // reference pixel model
    // ------------------------------------------------------------
    function automatic color_t expected_color(input int h, input int v);
        int rel, px, py, cx, cy, mx, my;
        if (h >= H_VISIBLE || v >= V_VISIBLE)
            return 12'h000;
        if (exp_state == IDLE)
            return COLOR_LOBBY;
        if (v == HUD_TOP - 1 || v == HUD_TOP)
            return COLOR_SEPARATOR;
        if (v > HUD_TOP) begin
            if (h < MINI_LEFT || h >= MINI_RIGHT)
                return COLOR_HUD;
            mx = (h - MINI_LEFT) * 2;  // half scale minimap
            my = (v - HUD_TOP) * 2;
            if (within_radius(mx, int'(p1_x)) && within_radius(my, int'(p1_y)))
                return COLOR_P1;
            if (within_radius(mx, int'(p2_x)) && within_radius(my, int'(p2_y)))
                return COLOR_P2;
            return PALETTE[map_copy[my * MAP_WIDTH + mx]];
        end
        if (h == VIEW_WIDTH - 1 || h == VIEW_WIDTH)
            return COLOR_SEPARATOR;
        rel = (h < VIEW_WIDTH) ? h : h - VIEW_WIDTH;
        px  = (h < VIEW_WIDTH) ? int'(p1_x) : int'(p2_x);
        py  = (h < VIEW_WIDTH) ? int'(p1_y) : int'(p2_y);
        if (rel >= MARK_LEFT && rel <= MARK_RIGHT && v >= MARK_TOP && v <= MARK_BOTTOM)
            return (h < VIEW_WIDTH) ? COLOR_P1 : COLOR_P2;
        // world cells wrap at the coordinate width
        cx = (rel / 8 + px - VIEW_OFFSET_X) & ((1 << COORD_W) - 1);
        cy = (v / 8 + py - VIEW_OFFSET_Y) & ((1 << COORD_W) - 1);
        if (cx >= MAP_WIDTH || cy >= MAP_HEIGHT)
            return COLOR_OFF_TRACK;
        return PALETTE[map_copy[cy * MAP_WIDTH + cx]];
    endfunction

    // frame starts at the falling vsync of pixel (0, 490)
    task automatic capture_frame(input string name);
        int   h, v, n;
        logic prev_vsync, found, hs, vs;
        n          = 0;
        prev_vsync = 1'b0;
        found      = 1'b0;
        while (!found && n <= FRAME_CYCLES) begin
            @(negedge clk_25MHz);
            found      = prev_vsync && !vsync;
            prev_vsync = vsync;
            n++;
        end
        if (!found) begin
            $display("%s: no falling vsync edge within one frame", name);
            test_errors++;
            return;
        end
        h = 0;
        v = V_VISIBLE + V_FRONT;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0)
                @(negedge clk_25MHz);
            hs = !(h >= H_VISIBLE + H_FRONT && h < H_VISIBLE + H_FRONT + H_SYNC);
            vs = !(v >= V_VISIBLE + V_FRONT && v < V_VISIBLE + V_FRONT + V_SYNC);
            compare($sformatf("%s pixel (%0d,%0d)", name, h, v),
                    {18'd0, hs, vs, expected_color(h, v)},
                    {18'd0, hsync, vsync, vga_red, vga_green, vga_blue});
            h++;
            if (h == H_TOTAL) begin
                h = 0;
                v = (v == V_TOTAL - 1) ? 0 : v + 1;
            end
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic after_reset();
        repeat (9) @(posedge clk_25MHz);
        @(negedge clk_25MHz);
        compare("reset syncs", 32'h3, {30'd0, hsync, vsync});
        compare("reset rgb", 32'h0, {20'd0, vga_red, vga_green, vga_blue});
        @(posedge clk_25MHz);
        #2;
        rst = 1'b0;
        repeat (20) expect_led("reset led", IDLE);
        report_test("reset");
    endtask

    task automatic state_flow();
        int t_start, t_seen, t_unused;
        strobe(SEL_START, t_start);
        expect_led("state flow start", COUNTDOWN);
        wait_for_led("state flow countdown", RACING, t_seen);
        compare("state flow countdown cycles", COUNT_CYCLES, t_seen - t_start);
        strobe(SEL_PAUSE, t_unused);
        expect_led("state flow pause", PAUSE);
        strobe(SEL_PAUSE, t_unused);
        expect_led("state flow resume", RACING);
        strobe(SEL_DONE, t_unused);
        expect_led("state flow finish", FINISH);
        strobe(SEL_START, t_unused);
        expect_led("state flow lobby", IDLE);
        report_test("state flow");
    endtask

    // leaves the race running
    task automatic countdown_pause();
        int t_start, t_pause, t_resume, t_seen;
        strobe(SEL_START, t_start);
        repeat (50) @(posedge clk_25MHz);
        strobe(SEL_PAUSE, t_pause);
        expect_led("countdown pause enter", PAUSE);
        repeat (40) @(posedge clk_25MHz);
        strobe(SEL_PAUSE, t_resume);
        expect_led("countdown pause leave", COUNTDOWN);
        wait_for_led("countdown pause", RACING, t_seen);
        compare("countdown pause cycles", COUNT_CYCLES + t_resume - t_pause, t_seen - t_start);
        report_test("countdown pause");
    endtask

    task automatic idle_frame();
        exp_state = IDLE;
        capture_frame("idle frame");
        report_test("idle frame");
    endtask

    task automatic racing_frame();
        set_players(100, 80, 210, 150);
        exp_state = RACING;
        capture_frame("racing frame");
        report_test("racing frame");
    endtask

    task automatic map_edge();
        int         t_unused, addr;
        map_index_t fresh;
        set_players(2, 3, 315, 236);
        capture_frame("map edge");
        strobe(SEL_PAUSE, t_unused);
        expect_led("map edge pause", PAUSE);
        exp_state = PAUSE;
        addr  = 10 * MAP_WIDTH + 10;  // right of the p1 marker
        fresh = map_copy[addr] ^ 4'h5;
        write_cell(addr, fresh);
        @(posedge clk_25MHz);
        #2;
        map_we = 1'b0;
        capture_frame("map edge rewrite");
        report_test("map edge");
    endtask

    initial begin
        rst          = 1'b1;
        start_btn    = 1'b0;
        pause_btn    = 1'b0;
        race_done    = 1'b0;
        p1_x         = '0;
        p1_y         = '0;
        p2_x         = '0;
        p2_y         = '0;
        map_we       = 1'b0;
        map_addr     = '0;
        map_wdata    = '0;
        exp_state    = IDLE;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;

        after_reset();
        idle_frame();
        load_map();
        state_flow();
        countdown_pause();
        racing_frame();
        map_edge();

        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, total_errors,
                 u_race_display_top.u_race_display_chk.assert_fails);
        if (tests_failed == 0 && u_race_display_top.u_race_display_chk.assert_fails == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
